// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_ddr_subsys \
		-f ddr_subsys.f -o tb_ddr_subsys
	./obj_dir/tb_ddr_subsys > sim.log 2>&1
	cat sim.log
	! grep -q "=== FAIL ===" sim.log

clean:
	rm -rf obj_dir sim.log

// File: ddr_subsys.f
design/ddr_pkg.sv
design/ddr_req_fifo.sv
design/ddr_req_arbiter.sv
design/ddr_model.sv
design/ddr_subsys.sv
test/tb_ddr_subsys.sv

// File: design/ddr_model.sv
`timescale 1ns/1ps

module ddr_model import ddr_pkg::*; (
    input  logic              clock,
    input  logic              reset_n,
    input  logic              empty,
    input  ddr_req_t          head_req,
    output logic              pop,
    output logic              done,
    output logic              done_burst,
    output logic [word_w-1:0] rdata_word,
    output logic [line_w-1:0] rdata_line
);

    logic [word_w-1:0]    mem [ddr_depth];  // main memory, one word per index
    ddr_req_t             cur_req;          // request being served
    logic                 busy;
    logic [lat_cnt_w-1:0] cnt;              // cycles since pop, starts at 1
    logic [lat_cnt_w-1:0] last_cnt;
    logic                 finish;           // final edge of the access

    // take a new request only when idle
    assign pop = !busy && !empty;

    assign last_cnt = cur_req.burst ? lat_cnt_w'(burst_latency - 1)
                                    : lat_cnt_w'(single_latency - 1);
    assign finish   = busy && (cnt == last_cnt);

    // latch the popped head
    always_ff @(posedge clock) begin
        if (pop)
            cur_req <= head_req;
    end

    // latency counter and completion pulse
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            busy       <= 1'b0;
            cnt        <= '0;
            done       <= 1'b0;
            done_burst <= 1'b0;
        end else begin
            done <= 1'b0;          // single-cycle pulse
            if (pop) begin
                busy <= 1'b1;
                cnt  <= lat_cnt_w'(1);
            end else if (finish) begin
                busy       <= 1'b0;
                cnt        <= '0;
                done       <= 1'b1;  // lands exactly latency cycles after pop
                done_burst <= cur_req.burst;
            end else if (busy) begin
                cnt <= cnt + lat_cnt_w'(1);
            end
        end
    end

    // array updates happen at the completion edge
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < ddr_depth; i++)
                mem[i] <= '0;
        end else if (finish && cur_req.write) begin
            if (cur_req.burst) begin
                // eight consecutive words from the line
                for (int k = 0; k < line_words; k++)
                    mem[cur_req.index + ddr_index_w'(k)] <= cur_req.wdata[k*word_w +: word_w];
            end else begin
                // masked merge, unmasked bits keep old value
                mem[cur_req.index] <= (mem[cur_req.index] & ~cur_req.wmask)
                                    | (cur_req.wdata[word_w-1:0] & cur_req.wmask);
            end
        end
    end

    // read results, held until the next read of the same width
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rdata_word <= '0;
            rdata_line <= '0;
        end else if (finish && !cur_req.write) begin
            if (cur_req.burst) begin
                for (int k = 0; k < line_words; k++)
                    rdata_line[k*word_w +: word_w] <= mem[cur_req.index + ddr_index_w'(k)];
            end else begin
                rdata_word <= mem[cur_req.index];
            end
        end
    end

    // back-to-back completions cannot occur, every access takes many cycles
    a_done_single: assert property (@(posedge clock) disable iff (!reset_n)
        done |=> !done);

endmodule

// File: design/ddr_pkg.sv
package ddr_pkg;

    // memory geometry
    localparam int ddr_index_w = 12;     // word index width
    localparam int ddr_depth   = 4096;   // 64-bit words in the array
    localparam int word_w      = 64;     // single access width
    localparam int line_w      = 512;    // burst line width
    localparam int line_words  = 8;      // words per burst, index aligned to this

    // fixed access latencies, counted from pop to done
    localparam int single_latency = 64;
    localparam int burst_latency  = 80;
    localparam int lat_cnt_w      = $clog2(burst_latency);  // wide enough for either count

    // request queue sizing
    localparam int req_fifo_depth = 2;
    localparam int req_fifo_ptr_w = $clog2(req_fifo_depth);
    localparam int req_fifo_cnt_w = $clog2(req_fifo_depth + 1);

    // one queued memory request
    typedef struct packed {
        logic                   burst;  // 1 = 512-bit line, 0 = 64-bit word
        logic                   write;  // 1 = store, 0 = load
        logic [ddr_index_w-1:0] index;  // word index
        logic [line_w-1:0]      wdata;  // single store uses the low word only
        logic [word_w-1:0]      wmask;  // bit mask, single stores only
    } ddr_req_t;

endpackage

// File: design/ddr_req_arbiter.sv
`timescale 1ns/1ps

module ddr_req_arbiter import ddr_pkg::*; (
    input  logic                   clock,
    input  logic                   reset_n,
    // data client, single words
    input  logic                   data_req,
    input  logic                   data_write,
    input  logic [ddr_index_w-1:0] data_index,
    input  logic [word_w-1:0]      data_wdata,
    input  logic [word_w-1:0]      data_wmask,
    // line client, bursts
    input  logic                   line_req,
    input  logic                   line_write,
    input  logic [ddr_index_w-1:0] line_index,
    input  logic [line_w-1:0]      line_wdata,
    // queue side
    input  logic                   full,
    output logic                   push,
    output ddr_req_t               push_req,
    // completion from the model
    input  logic                   done,
    input  logic                   done_burst,
    // client status
    output logic                   data_busy,
    output logic                   line_busy,
    output logic                   data_done,
    output logic                   line_done
);

    ddr_req_t data_slot;   // captured data request
    ddr_req_t line_slot;   // captured line request
    logic     data_pend;   // captured but not yet in the queue
    logic     line_pend;
    logic     push_data;   // this push takes the data slot

    // capture request payloads on the strobe
    always_ff @(posedge clock) begin
        if (data_req) begin
            data_slot.burst <= 1'b0;
            data_slot.write <= data_write;
            data_slot.index <= data_index;
            data_slot.wdata <= {{(line_w - word_w){1'b0}}, data_wdata};  // low word only
            data_slot.wmask <= data_wmask;
        end
        if (line_req) begin
            line_slot.burst <= 1'b1;
            line_slot.write <= line_write;
            line_slot.index <= line_index;
            line_slot.wdata <= line_wdata;
            line_slot.wmask <= '0;  // bursts write whole words
        end
    end

    // data side has priority over the line side
    assign push_data = data_pend;
    assign push      = !full && (data_pend || line_pend);
    assign push_req  = push_data ? data_slot : line_slot;

    // model done steered back to its client
    assign data_done = done && !done_burst;
    assign line_done = done && done_burst;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            data_pend <= 1'b0;
            line_pend <= 1'b0;
            data_busy <= 1'b0;
            line_busy <= 1'b0;
        end else begin
            // pending flags: set by strobe, cleared once queued
            if (data_req)
                data_pend <= 1'b1;
            else if (push && push_data)
                data_pend <= 1'b0;
            if (line_req)
                line_pend <= 1'b1;
            else if (push && !push_data)
                line_pend <= 1'b0;
            // busy spans strobe to done
            if (data_req)
                data_busy <= 1'b1;
            else if (data_done)
                data_busy <= 1'b0;
            if (line_req)
                line_busy <= 1'b1;
            else if (line_done)
                line_busy <= 1'b0;
        end
    end

    // a client may only strobe while idle
    a_data_req_idle: assert property (@(posedge clock) disable iff (!reset_n)
        data_req |-> !data_busy);
    a_line_req_idle: assert property (@(posedge clock) disable iff (!reset_n)
        line_req |-> !line_busy);

    // bursts start on a line boundary
    a_line_aligned: assert property (@(posedge clock) disable iff (!reset_n)
        line_req |-> ((line_index & ddr_index_w'(line_words - 1)) == '0));

endmodule

// File: design/ddr_req_fifo.sv
`timescale 1ns/1ps

module ddr_req_fifo import ddr_pkg::*; (
    input  logic     clock,
    input  logic     reset_n,
    input  logic     push,
    input  ddr_req_t push_req,
    input  logic     pop,
    output ddr_req_t head_req,
    output logic     full,
    output logic     empty
);

    ddr_req_t                  entries [req_fifo_depth];
    logic [req_fifo_ptr_w-1:0] wr_ptr;
    logic [req_fifo_ptr_w-1:0] rd_ptr;
    logic [req_fifo_cnt_w-1:0] count;   // entries held

    localparam logic [req_fifo_ptr_w-1:0] last_ptr = req_fifo_ptr_w'(req_fifo_depth - 1);

    // entry storage, written at the tail
    always_ff @(posedge clock) begin
        if (push)
            entries[wr_ptr] <= push_req;
    end

    assign head_req = entries[rd_ptr];  // fall-through head
    assign full     = (count == req_fifo_cnt_w'(req_fifo_depth));
    assign empty    = (count == '0);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + req_fifo_ptr_w'(1);
            if (pop)
                rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + req_fifo_ptr_w'(1);
            case ({push, pop})
                2'b10:   count <= count + req_fifo_cnt_w'(1);
                2'b01:   count <= count - req_fifo_cnt_w'(1);
                default: count <= count;  // both or neither, no change
            endcase
        end
    end

    // arbiter and model must respect the flags
    a_no_push_full: assert property (@(posedge clock) disable iff (!reset_n)
        push |-> !full);
    a_no_pop_empty: assert property (@(posedge clock) disable iff (!reset_n)
        pop |-> !empty);

endmodule

// File: design/ddr_subsys.sv
`timescale 1ns/1ps

module ddr_subsys import ddr_pkg::*; (
    input  logic                   clock,
    input  logic                   reset_n,
    // data client
    input  logic                   data_req,
    input  logic                   data_write,
    input  logic [ddr_index_w-1:0] data_index,
    input  logic [word_w-1:0]      data_wdata,
    input  logic [word_w-1:0]      data_wmask,
    output logic [word_w-1:0]      data_rdata,
    output logic                   data_busy,
    output logic                   data_done,
    // line client
    input  logic                   line_req,
    input  logic                   line_write,
    input  logic [ddr_index_w-1:0] line_index,
    input  logic [line_w-1:0]      line_wdata,
    output logic [line_w-1:0]      line_rdata,
    output logic                   line_busy,
    output logic                   line_done
);

    logic     push;
    logic     full;
    ddr_req_t push_req;
    logic     pop;
    logic     empty;
    ddr_req_t head_req;
    logic     done;
    logic     done_burst;   // 1 = line client finished

    ddr_req_arbiter i_arbiter (
        .clock      (clock),
        .reset_n    (reset_n),
        .data_req   (data_req),
        .data_write (data_write),
        .data_index (data_index),
        .data_wdata (data_wdata),
        .data_wmask (data_wmask),
        .line_req   (line_req),
        .line_write (line_write),
        .line_index (line_index),
        .line_wdata (line_wdata),
        .full       (full),
        .push       (push),
        .push_req   (push_req),
        .done       (done),
        .done_burst (done_burst),
        .data_busy  (data_busy),
        .line_busy  (line_busy),
        .data_done  (data_done),
        .line_done  (line_done)
    );

    ddr_req_fifo i_fifo (
        .clock    (clock),
        .reset_n  (reset_n),
        .push     (push),
        .push_req (push_req),
        .pop      (pop),
        .head_req (head_req),
        .full     (full),
        .empty    (empty)
    );

    // read results go straight out to the clients
    ddr_model i_model (
        .clock      (clock),
        .reset_n    (reset_n),
        .empty      (empty),
        .head_req   (head_req),
        .pop        (pop),
        .done       (done),
        .done_burst (done_burst),
        .rdata_word (data_rdata),
        .rdata_line (line_rdata)
    );

endmodule

// File: test/tb_ddr_subsys.sv
`timescale 1ns/1ps

module tb_ddr_subsys import ddr_pkg::*; ();

    localparam int timeout_cycles = 500;

    logic                   clock = 1'b0;
    logic                   reset_n;
    logic                   data_req, data_write;
    logic [ddr_index_w-1:0] data_index;
    logic [word_w-1:0]      data_wdata, data_wmask, data_rdata;
    logic                   data_busy, data_done;
    logic                   line_req, line_write;
    logic [ddr_index_w-1:0] line_index;
    logic [line_w-1:0]      line_wdata, line_rdata;
    logic                   line_busy, line_done;

    logic [word_w-1:0] ref_mem [ddr_depth];  // expected memory contents
    int errors = 0;
    int timeouts = 0;
    int cycle_no = 0;                        // free-running edge count
    int data_issued = 0;
    int line_issued = 0;
    int data_done_total = 0;                 // counted from the done pins
    int line_done_total = 0;
    int data_done_at = 0;
    int line_done_at = 0;

    ddr_subsys i_dut (.*);

    always #50 clock = ~clock;  // 100 ns period

    always @(posedge clock) cycle_no++;

    // done pulses sampled mid-cycle
    always @(negedge clock) begin
        if (data_done) data_done_total++;
        if (line_done) line_done_total++;
    end

    task automatic check_word(input string name, input logic [word_w-1:0] got,
                              input logic [word_w-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_line(input string name, input logic [line_w-1:0] got,
                              input logic [line_w-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [word_w-1:0] rand_word();
        return {$urandom, $urandom};
    endfunction

    function automatic logic [line_w-1:0] rand_line();
        logic [line_w-1:0] line;
        for (int k = 0; k < line_words; k++)
            line[k*word_w +: word_w] = rand_word();
        return line;
    endfunction

    // eight reference words with the lowest index in the low slice
    function automatic logic [line_w-1:0] ref_line(input logic [ddr_index_w-1:0] index);
        logic [line_w-1:0] line;
        for (int k = 0; k < line_words; k++)
            line[k*word_w +: word_w] = ref_mem[index + ddr_index_w'(k)];
        return line;
    endfunction

    function automatic logic [ddr_index_w-1:0] low_index();  // data side region
        return {1'b0, 11'($urandom)};
    endfunction

    function automatic logic [ddr_index_w-1:0] high_line();  // aligned line in the upper region
        return {1'b1, 8'($urandom), 3'b000};
    endfunction

    task automatic data_access(input logic write, input logic [ddr_index_w-1:0] index,
                               input logic [word_w-1:0] wdata, input logic [word_w-1:0] wmask);
        int cycles;
        cycles = 0;
        while (data_busy && cycles < timeout_cycles) begin  // previous request draining
            @(posedge clock);
            #1;
            cycles++;
        end
        if (data_busy) begin
            $display("data client never went idle, request not issued");
            timeouts++;
            return;
        end
        data_req   = 1'b1;
        data_write = write;
        data_index = index;
        data_wdata = wdata;
        data_wmask = wmask;
        data_issued++;
        @(posedge clock);
        #1;
        data_req = 1'b0;
        cycles   = 1;
        while (!data_done && cycles < timeout_cycles) begin
            check_bit("data_busy", data_busy, 1'b1);  // held until own done
            @(posedge clock);
            #1;
            cycles++;
        end
        if (!data_done) begin
            $display("data request at index %h never completed", index);
            timeouts++;
            return;
        end
        data_done_at = cycle_no;
        if (cycles < single_latency) begin
            $display("data request finished after only %0d cycles", cycles);
            errors++;
        end
        if (write) begin
            for (int b = 0; b < word_w; b++) begin
                if (wmask[b])
                    ref_mem[index][b] = wdata[b];  // masked bits take the store data
            end
        end else begin
            check_word("data_rdata", data_rdata, ref_mem[index]);
        end
    endtask

    task automatic line_access(input logic write, input logic [ddr_index_w-1:0] index,
                               input logic [line_w-1:0] wdata);
        int cycles;
        cycles = 0;
        while (line_busy && cycles < timeout_cycles) begin
            @(posedge clock);
            #1;
            cycles++;
        end
        if (line_busy) begin
            $display("line client never went idle, request not issued");
            timeouts++;
            return;
        end
        line_req   = 1'b1;
        line_write = write;
        line_index = index;
        line_wdata = wdata;
        line_issued++;
        @(posedge clock);
        #1;
        line_req = 1'b0;
        cycles   = 1;
        while (!line_done && cycles < timeout_cycles) begin
            check_bit("line_busy", line_busy, 1'b1);
            @(posedge clock);
            #1;
            cycles++;
        end
        if (!line_done) begin
            $display("line request at index %h never completed", index);
            timeouts++;
            return;
        end
        line_done_at = cycle_no;
        if (cycles < burst_latency) begin
            $display("line request finished after only %0d cycles", cycles);
            errors++;
        end
        if (write) begin
            for (int k = 0; k < line_words; k++)
                ref_mem[index + ddr_index_w'(k)] = wdata[k*word_w +: word_w];
        end else begin
            check_line("line_rdata", line_rdata, ref_line(index));
        end
    endtask

    task automatic reset_state();
        check_bit("data_busy", data_busy, 1'b0);
        check_bit("line_busy", line_busy, 1'b0);
        check_bit("data_done", data_done, 1'b0);
        check_bit("line_done", line_done, 1'b0);
        for (int i = 0; i < 3; i++)
            data_access(1'b0, ddr_index_w'($urandom), '0, '0);  // reference is all zero
        line_access(1'b0, high_line(), '0);
    endtask

    task automatic masked_stores();
        logic [ddr_index_w-1:0] index;
        for (int i = 0; i < 20; i++) begin
            index = low_index();
            data_access(1'b1, index, rand_word(), rand_word());
            data_access(1'b1, index, rand_word(), rand_word());  // merge over non-zero word
            data_access(1'b0, index, '0, '0);
        end
    endtask

    task automatic burst_round_trip();
        logic [ddr_index_w-1:0] index;
        index = high_line();
        line_access(1'b1, index, rand_line());
        line_access(1'b0, index, '0);
    endtask

    task automatic mixed_widths();
        logic [ddr_index_w-1:0] index;
        index = {1'b0, 8'($urandom), 3'b000};
        line_access(1'b1, index, rand_line());
        for (int k = 0; k < line_words; k++)
            data_access(1'b0, index + ddr_index_w'(k), '0, '0);  // one slice each
        data_access(1'b1, index + ddr_index_w'(3), rand_word(), rand_word());
        line_access(1'b0, index, '0);  // word 3 now merged
    endtask

    task automatic concurrent_clients();
        logic [ddr_index_w-1:0] windex;
        logic [ddr_index_w-1:0] lindex;
        windex = low_index();
        lindex = high_line();
        fork
            data_access(1'b1, windex, rand_word(), '1);
            line_access(1'b1, lindex, rand_line());
        join
        if (data_done_at >= line_done_at) begin
            $display("data client did not finish before the line client on a shared strobe");
            errors++;
        end
        fork
            data_access(1'b0, windex, '0, '0);
            line_access(1'b0, lindex, '0);
        join
    endtask

    task automatic back_pressure();
        fork
            for (int i = 0; i < 6; i++) begin
                logic [ddr_index_w-1:0] index;
                index = low_index();
                data_access(1'b1, index, rand_word(), rand_word());
                data_access(1'b0, index, '0, '0);
            end
            for (int i = 0; i < 4; i++) begin
                logic [ddr_index_w-1:0] index;
                index = high_line();
                line_access(1'b1, index, rand_line());
                line_access(1'b0, index, '0);
            end
        join
        @(posedge clock);  // let the last pulse reach the counters
        #1;
        if (data_done_total != data_issued || line_done_total != line_issued) begin
            $display("done pulses %0d/%0d do not match requests %0d/%0d",
                     data_done_total, line_done_total, data_issued, line_issued);
            errors++;
        end
    endtask

    initial begin
        void'($urandom(32'h709f46d5));
        reset_n    = 1'b0;
        data_req   = 1'b0;
        data_write = 1'b0;
        data_index = '0;
        data_wdata = '0;
        data_wmask = '0;
        line_req   = 1'b0;
        line_write = 1'b0;
        line_index = '0;
        line_wdata = '0;
        for (int i = 0; i < ddr_depth; i++)
            ref_mem[i] = '0;
        repeat (10) @(posedge clock);
        #1;
        reset_n = 1'b1;
        @(posedge clock);
        #1;
        reset_state();
        masked_stores();
        burst_round_trip();
        mixed_widths();
        concurrent_clients();
        back_pressure();
        $display("errors: %0d check, %0d timeout", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
